// File: common/cnn_pkg.sv
//////////////////////////////////////////////////////////////////////
// CNN front-end package: sizes, address map and sequencer states
//////////////////////////////////////////////////////////////////////
`default_nettype none

package cnn_pkg;

    localparam int PIX_W      = 8;
    localparam int LANES      = 4;    // One 2x2 quad per word
    localparam int WORD_W     = 32;
    localparam int MEM_ADDR_W = 6;

    // Image geometry, 5x5 quads of 2x2 pixels
    localparam int IMG_QUADS = 5;
    localparam int OUT_DIM   = IMG_QUADS - 1;
    localparam int TAPS      = 9;
    localparam int TAP_W     = 4;

    localparam int IMAGE_BASE  = 0;   // 25 image words
    localparam int RESULT_BASE = 32;  // 4 packed result words

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        STREAM,
        DONE
    } reader_state_t;

    typedef enum logic [1:0] {
        COLLECT,
        WRITE,
        FINISH
    } writer_state_t;

endpackage

`default_nettype wire

// File: dv/conv_seq_tb.sv
//////////////////////////////////////////////////////////////////////
// Conv sequencer testbench: host loads an image, MAC model answers
//////////////////////////////////////////////////////////////////////
`default_nettype none

module conv_seq_tb;

    logic                           clk        = 1'b0;
    logic                           reset      = 1'b1;
    logic                           start      = 1'b0;
    logic                           busy;
    logic                           host_cyc   = 1'b0;
    logic                           host_stb   = 1'b0;
    logic                           host_we    = 1'b0;
    logic [cnn_pkg::MEM_ADDR_W-1:0] host_adr   = '0;
    logic [cnn_pkg::WORD_W-1:0]     host_dat_w = '0;
    logic [cnn_pkg::WORD_W-1:0]     host_dat_r;
    logic                           host_ack;
    logic                           win_valid;
    logic                           win_ready  = 1'b0;
    logic [cnn_pkg::WORD_W-1:0]     win_pixels;
    logic [cnn_pkg::TAP_W-1:0]      win_tap;
    logic                           win_last;
    logic                           res_valid  = 1'b0;
    logic [cnn_pkg::PIX_W-1:0]      res_data   = '0;
    logic                           res_ready;

    logic [cnn_pkg::WORD_W-1:0] model_mem [2**cnn_pkg::MEM_ADDR_W];  // Image and results
    logic [cnn_pkg::WORD_W-1:0] exp_rd;
    logic [cnn_pkg::WORD_W-1:0] exp_pixels;
    logic [cnn_pkg::TAP_W-1:0]  exp_tap = '0;
    logic [cnn_pkg::WORD_W-1:0] held_pixels = '0;
    logic [cnn_pkg::TAP_W-1:0]  held_tap = '0;
    logic                       held_last = 1'b0;
    logic [cnn_pkg::PIX_W-1:0]  mac_queue [$];   // Results still owed by the MAC
    int                         tile_cnt = 0;
    int                         results_taken = 0;
    int                         cycle_cnt = 0;

    // Stream seeds derived from 83
    logic [31:0] img_rng   = 32'd83;
    logic [31:0] ready_rng = 32'd83 ^ 32'h1357_0000;
    logic [31:0] valid_rng = 32'd83 ^ 32'h2468_0000;

    conv_seq_top u_conv_seq_top (
        .clk, .reset, .start, .busy,
        .host_cyc, .host_stb, .host_we, .host_adr, .host_dat_w, .host_dat_r, .host_ack,
        .win_valid, .win_ready, .win_pixels, .win_tap, .win_last,
        .res_valid, .res_data, .res_ready
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Pixel at image row y, column x
    function automatic logic [7:0] image_pixel(input int y, input int x);
        int          idx;
        logic [31:0] word;
        idx  = cnn_pkg::IMAGE_BASE + (y / 2) * cnn_pkg::IMG_QUADS + x / 2;
        word = model_mem[idx[cnn_pkg::MEM_ADDR_W-1:0]] >> (8 * ((y % 2) * 2 + x % 2));
        return word[7:0];
    endfunction

    // Four pool candidates of one tap, lane 0 in the low byte
    function automatic logic [31:0] window_beat(input int tile, input int tap);
        int top;
        int left;
        top  = 2 * (tile / cnn_pkg::OUT_DIM) + tap / 3;
        left = 2 * (tile % cnn_pkg::OUT_DIM) + tap % 3;
        return {image_pixel(top + 1, left + 1), image_pixel(top + 1, left),
                image_pixel(top, left + 1), image_pixel(top, left)};
    endfunction

    always_comb exp_pixels = window_beat(tile_cnt, int'(exp_tap));
    assign exp_rd = model_mem[host_adr];

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic wait_for_ack();
        @(posedge clk);
        while (!host_ack)
            @(posedge clk);
        host_cyc <= 1'b0;   // Drop in the cycle after ack
        host_stb <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic write_word(input int adr, input logic [31:0] data);
        @(posedge clk);
        host_cyc   <= 1'b1;
        host_stb   <= 1'b1;
        host_we    <= 1'b1;
        host_adr   <= adr[cnn_pkg::MEM_ADDR_W-1:0];
        host_dat_w <= data;
        wait_for_ack();
    endtask

    task automatic read_word(input int adr);
        @(posedge clk);
        host_cyc <= 1'b1;
        host_stb <= 1'b1;
        host_we  <= 1'b0;
        host_adr <= adr[cnn_pkg::MEM_ADDR_W-1:0];
        wait_for_ack();
    endtask

    // Reference tap and tile position, advanced on accepted beats
    always @(posedge clk) begin
        held_pixels <= win_pixels;
        held_tap    <= win_tap;
        held_last   <= win_last;
        if (reset) begin
            exp_tap  <= '0;
            tile_cnt <= 0;
        end else if (win_valid && win_ready) begin
            if (int'(exp_tap) == cnn_pkg::TAPS - 1) begin
                exp_tap  <= '0;
                tile_cnt <= tile_cnt + 1;
            end else begin
                exp_tap <= exp_tap + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        ready_rng = xorshift32(ready_rng);
        win_ready <= ready_rng[1:0] != 2'd0;   // Ready about 3 of 4 cycles
    end

    // MAC model, holds back results so it runs a few tiles behind
    always @(posedge clk) begin
        valid_rng = xorshift32(valid_rng);
        if (!reset) begin
            if (win_valid && win_ready && win_last)
                mac_queue.push_back(8'(tile_cnt * 7 + 3));
            if (res_valid && res_ready) begin
                void'(mac_queue.pop_front());
                results_taken <= results_taken + 1;
            end
            if (!res_valid || res_ready) begin
                if ((mac_queue.size() > 2 || tile_cnt == cnn_pkg::OUT_DIM * cnn_pkg::OUT_DIM)
                    && mac_queue.size() > 0 && valid_rng[2:0] < 3'd4) begin
                    res_valid <= 1'b1;
                    res_data  <= mac_queue[0];
                end else begin
                    res_valid <= 1'b0;
                end
            end
        end
    end

    // A full run takes well under 1000 cycles
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == 3000) begin
            $display("Timeout: the run did not finish within 3000 cycles");
            abort_run();
        end
    end

    idle_valid_a: assert property (@(posedge clk) $fell(reset) |-> !win_valid)
        else report_mismatch("win_valid", 32'd0, 32'(win_valid));
    idle_ready_a: assert property (@(posedge clk) $fell(reset) |-> !res_ready)
        else report_mismatch("res_ready", 32'd0, 32'(res_ready));
    idle_busy_a: assert property (@(posedge clk) $fell(reset) |-> !busy)
        else report_mismatch("busy", 32'd0, 32'(busy));
    idle_ack_a: assert property (@(posedge clk) $fell(reset) |-> !host_ack)
        else report_mismatch("host_ack", 32'd0, 32'(host_ack));

    read_data_a: assert property (@(posedge clk) disable iff (reset)
        host_ack && !host_we |-> host_dat_r == exp_rd)
        else report_mismatch("host_dat_r", exp_rd, host_dat_r);

    busy_rise_a: assert property (@(posedge clk) disable iff (reset)
        start && !busy |=> busy)
        else report_mismatch("busy", 32'd1, 32'(busy));

    beat_tap_a: assert property (@(posedge clk) disable iff (reset)
        win_valid && win_ready |-> win_tap == exp_tap)
        else report_mismatch("win_tap", 32'(exp_tap), 32'(win_tap));
    beat_pixels_a: assert property (@(posedge clk) disable iff (reset)
        win_valid && win_ready |-> win_pixels == exp_pixels)
        else report_mismatch("win_pixels", exp_pixels, win_pixels);
    beat_last_a: assert property (@(posedge clk) disable iff (reset)
        win_valid && win_ready |-> win_last == (int'(exp_tap) == cnn_pkg::TAPS - 1))
        else report_mismatch("win_last", 32'(int'(exp_tap) == 8), 32'(win_last));

    // Beat held while the MAC stalls
    hold_valid_a: assert property (@(posedge clk) disable iff (reset)
        win_valid && !win_ready |=> win_valid)
        else report_mismatch("win_valid", 32'd1, 32'(win_valid));
    hold_pixels_a: assert property (@(posedge clk) disable iff (reset)
        win_valid && !win_ready |=> win_pixels == held_pixels)
        else report_mismatch("win_pixels", held_pixels, win_pixels);
    hold_tap_a: assert property (@(posedge clk) disable iff (reset)
        win_valid && !win_ready |=> win_tap == held_tap)
        else report_mismatch("win_tap", 32'(held_tap), 32'(win_tap));
    hold_last_a: assert property (@(posedge clk) disable iff (reset)
        win_valid && !win_ready |=> win_last == held_last)
        else report_mismatch("win_last", 32'(held_last), 32'(win_last));

    initial begin
        int         idx;
        logic [7:0] res_byte;
        for (int a = 0; a < 2**cnn_pkg::MEM_ADDR_W; a++)
            model_mem[a[cnn_pkg::MEM_ADDR_W-1:0]] = '0;
        for (int a = 0; a < cnn_pkg::IMG_QUADS * cnn_pkg::IMG_QUADS; a++) begin
            img_rng = xorshift32(img_rng);
            idx     = cnn_pkg::IMAGE_BASE + a;
            model_mem[idx[cnn_pkg::MEM_ADDR_W-1:0]] = img_rng;
        end
        // Result n lands in lane n mod 4 of word n div 4
        for (int n = 0; n < cnn_pkg::OUT_DIM * cnn_pkg::OUT_DIM; n++) begin
            idx      = cnn_pkg::RESULT_BASE + n / cnn_pkg::LANES;
            res_byte = 8'(n * 7 + 3);
            model_mem[idx[cnn_pkg::MEM_ADDR_W-1:0]] = model_mem[idx[cnn_pkg::MEM_ADDR_W-1:0]] |
                                                      ({24'd0, res_byte} << (8 * (n % 4)));
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int a = 0; a < cnn_pkg::IMG_QUADS * cnn_pkg::IMG_QUADS; a++) begin
            idx = cnn_pkg::IMAGE_BASE + a;
            write_word(idx, model_mem[idx[cnn_pkg::MEM_ADDR_W-1:0]]);
        end
        for (int a = 0; a < cnn_pkg::IMG_QUADS * cnn_pkg::IMG_QUADS; a += 4)
            read_word(cnn_pkg::IMAGE_BASE + a);

        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!busy)
            @(posedge clk);
        while (busy)
            @(posedge clk);

        for (int k = 0; k < 4; k++)
            read_word(cnn_pkg::RESULT_BASE + k);

        if (tile_cnt == 16 && results_taken == 16 && mac_queue.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Frame incomplete: %0d tiles streamed, %0d results taken",
                     tile_cnt, results_taken);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_seq/result_writer.sv
//////////////////////////////////////////////////////////////////////
// Result writer: packs four MAC result bytes per word and writes
// each full word to the result region
//////////////////////////////////////////////////////////////////////
`default_nettype none

module result_writer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    output logic                           active,
    input  logic                           res_valid,
    input  logic [cnn_pkg::PIX_W-1:0]      res_data,
    output logic                           res_ready,
    output logic                           m_cyc,
    output logic                           m_stb,
    output logic                           m_we,
    output logic [cnn_pkg::MEM_ADDR_W-1:0] m_adr,
    output logic [cnn_pkg::WORD_W-1:0]     m_dat_w,
    input  logic                           m_ack
);

    cnn_pkg::writer_state_t state;

    logic [1:0]                 lane;
    logic [1:0]                 word;
    logic [cnn_pkg::WORD_W-1:0] pack;
    logic                       take;
    logic                       last_word;
    int                         wr_addr;

    assign take      = state == cnn_pkg::COLLECT && res_valid && res_ready;
    assign last_word = int'(word) ==
                       cnn_pkg::OUT_DIM * cnn_pkg::OUT_DIM / cnn_pkg::LANES - 1;
    assign wr_addr   = cnn_pkg::RESULT_BASE + int'(word);

    assign m_adr   = wr_addr[cnn_pkg::MEM_ADDR_W-1:0];
    assign m_dat_w = pack;
    assign m_stb   = m_cyc;
    assign m_we    = 1'b1;
    assign active  = state != cnn_pkg::FINISH;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= cnn_pkg::FINISH;
            res_ready <= 1'b0;
            m_cyc     <= 1'b0;
            lane      <= '0;
            word      <= '0;
        end else begin
            case (state)
                cnn_pkg::COLLECT: begin
                    if (take) begin
                        lane <= lane + 2'd1;
                        if (int'(lane) == cnn_pkg::LANES - 1) begin
                            state     <= cnn_pkg::WRITE;
                            res_ready <= 1'b0;  // Stall MAC during the bus write
                            m_cyc     <= 1'b1;
                        end
                    end
                end
                cnn_pkg::WRITE: begin
                    if (m_ack) begin
                        m_cyc     <= 1'b0;
                        res_ready <= 1'b1;
                        word      <= word + 2'd1;
                        state     <= last_word ? cnn_pkg::FINISH : cnn_pkg::COLLECT;
                    end
                end
                default: begin
                    res_ready <= 1'b1;
                    if (start) begin
                        state <= cnn_pkg::COLLECT;
                        lane  <= '0;
                        word  <= '0;
                    end
                end
            endcase
        end
    end

    // First result ends up in lane 0 after four shifts
    always_ff @(posedge clk) begin
        if (take)
            pack <= {res_data, pack[cnn_pkg::WORD_W-1:cnn_pkg::PIX_W]};
    end

    no_ready_in_write_a: assert property (@(posedge clk) disable iff (reset)
        m_cyc |-> !res_ready);

endmodule

`default_nettype wire

// File: hw/conv_seq/tile_reader.sv
//////////////////////////////////////////////////////////////////////
// Tile reader: fetches each 4x4 tile as four quads and streams
// nine pool-window tap beats to the MAC
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tile_reader (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    output logic                           active,
    output logic                           m_cyc,
    output logic                           m_stb,
    output logic                           m_we,
    output logic [cnn_pkg::MEM_ADDR_W-1:0] m_adr,
    output logic [cnn_pkg::WORD_W-1:0]     m_dat_w,
    input  logic [cnn_pkg::WORD_W-1:0]     m_dat_r,
    input  logic                           m_ack,
    output logic                           win_valid,
    input  logic                           win_ready,
    output logic [cnn_pkg::WORD_W-1:0]     win_pixels,
    output logic [cnn_pkg::TAP_W-1:0]      win_tap,
    output logic                           win_last
);

    cnn_pkg::reader_state_t state;

    logic [1:0]                 tile_row;
    logic [1:0]                 tile_col;
    logic [1:0]                 quad_idx;   // TL, TR, BL, BR quad of the tile
    logic [1:0]                 tap_row;
    logic [1:0]                 tap_col;
    logic [cnn_pkg::TAP_W-1:0]  tap;
    logic [cnn_pkg::WORD_W-1:0] quad_buf [cnn_pkg::LANES];
    logic [1:0]                 pr;
    logic [1:0]                 pc;
    logic                       beat;
    logic                       last_tile;
    int                         fetch_addr;

    assign beat      = win_valid && win_ready;
    assign last_tile = int'(tile_row) == cnn_pkg::OUT_DIM - 1 &&
                       int'(tile_col) == cnn_pkg::OUT_DIM - 1;

    // Quad (row + qi[1], col + qi[0]) of the image
    assign fetch_addr = cnn_pkg::IMAGE_BASE +
                        (int'(tile_row) + int'(quad_idx[1])) * cnn_pkg::IMG_QUADS +
                        int'(tile_col) + int'(quad_idx[0]);

    assign m_adr   = fetch_addr[cnn_pkg::MEM_ADDR_W-1:0];
    assign m_stb   = m_cyc;
    assign m_we    = 1'b0;
    assign m_dat_w = '0;
    assign active  = state != cnn_pkg::IDLE;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cnn_pkg::IDLE;
            m_cyc    <= 1'b0;
            tile_row <= '0;
            tile_col <= '0;
            quad_idx <= '0;
            tap_row  <= '0;
            tap_col  <= '0;
            tap      <= '0;
        end else begin
            case (state)
                cnn_pkg::IDLE: begin
                    if (start) begin
                        state    <= cnn_pkg::FETCH;
                        tile_row <= '0;
                        tile_col <= '0;
                        quad_idx <= '0;
                    end
                end
                cnn_pkg::FETCH: begin
                    if (!m_cyc) begin
                        m_cyc <= 1'b1;
                    end else if (m_ack) begin
                        m_cyc    <= 1'b0;   // Drop in the cycle after ack
                        quad_idx <= quad_idx + 2'd1;
                        if (int'(quad_idx) == cnn_pkg::LANES - 1) begin
                            state   <= cnn_pkg::STREAM;
                            tap     <= '0;
                            tap_row <= '0;
                            tap_col <= '0;
                        end
                    end
                end
                cnn_pkg::STREAM: begin
                    if (beat) begin
                        tap <= tap + 1'b1;
                        if (tap_col == 2'd2) begin
                            tap_col <= '0;
                            tap_row <= tap_row + 2'd1;
                        end else begin
                            tap_col <= tap_col + 2'd1;
                        end
                        if (win_last) begin
                            state <= last_tile ? cnn_pkg::DONE : cnn_pkg::FETCH;
                            if (int'(tile_col) == cnn_pkg::OUT_DIM - 1) begin
                                tile_col <= '0;
                                tile_row <= tile_row + 2'd1;
                            end else begin
                                tile_col <= tile_col + 2'd1;
                            end
                        end
                    end
                end
                default: state <= cnn_pkg::IDLE;   // DONE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cnn_pkg::FETCH && m_cyc && m_ack)
            quad_buf[quad_idx] <= m_dat_r;
    end

    // Pixel p[r][c] lives in quad {r[1],c[1]}, lane {r[0],c[0]}
    always_comb begin
        win_pixels = '0;
        pr = '0;
        pc = '0;
        for (int l = 0; l < cnn_pkg::LANES; l++) begin
            pr = tap_row + 2'(l / 2);
            pc = tap_col + 2'(l % 2);
            win_pixels[l*cnn_pkg::PIX_W +: cnn_pkg::PIX_W] =
                quad_buf[{pr[1], pc[1]}][{pr[0], pc[0]}*cnn_pkg::PIX_W +: cnn_pkg::PIX_W];
        end
    end

    assign win_valid = state == cnn_pkg::STREAM;
    assign win_tap   = tap;
    assign win_last  = int'(tap) == cnn_pkg::TAPS - 1;

    beat_hold_a: assert property (@(posedge clk) disable iff (reset)
        win_valid && !win_ready |=> win_valid && $stable(win_pixels) &&
                                    $stable(win_tap) && $stable(win_last));

endmodule

`default_nettype wire

// File: hw/conv_seq_top.sv
//////////////////////////////////////////////////////////////////////
// Conv sequencer top: reader, writer and host share feature memory
//////////////////////////////////////////////////////////////////////
`default_nettype none

module conv_seq_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    output logic                           busy,
    input  logic                           host_cyc,
    input  logic                           host_stb,
    input  logic                           host_we,
    input  logic [cnn_pkg::MEM_ADDR_W-1:0] host_adr,
    input  logic [cnn_pkg::WORD_W-1:0]     host_dat_w,
    output logic [cnn_pkg::WORD_W-1:0]     host_dat_r,
    output logic                           host_ack,
    output logic                           win_valid,
    input  logic                           win_ready,
    output logic [cnn_pkg::WORD_W-1:0]     win_pixels,
    output logic [cnn_pkg::TAP_W-1:0]      win_tap,
    output logic                           win_last,
    input  logic                           res_valid,
    input  logic [cnn_pkg::PIX_W-1:0]      res_data,
    output logic                           res_ready
);

    logic                           rd_active;
    logic                           rd_cyc;
    logic                           rd_stb;
    logic                           rd_we;
    logic [cnn_pkg::MEM_ADDR_W-1:0] rd_adr;
    logic [cnn_pkg::WORD_W-1:0]     rd_dat_w;
    logic [cnn_pkg::WORD_W-1:0]     rd_dat_r;
    logic                           rd_ack;

    logic                           wr_active;
    logic                           wr_cyc;
    logic                           wr_stb;
    logic                           wr_we;
    logic [cnn_pkg::MEM_ADDR_W-1:0] wr_adr;
    logic [cnn_pkg::WORD_W-1:0]     wr_dat_w;
    logic                           wr_ack;

    logic                           mem_cyc;
    logic                           mem_stb;
    logic                           mem_we;
    logic [cnn_pkg::MEM_ADDR_W-1:0] mem_adr;
    logic [cnn_pkg::WORD_W-1:0]     mem_dat_w;
    logic [cnn_pkg::WORD_W-1:0]     mem_dat_r;
    logic                           mem_ack;

    assign busy = rd_active || wr_active;   // Writer finishes last

    tile_reader u_tile_reader (
        .clk, .reset, .start,
        .active     (rd_active),
        .m_cyc      (rd_cyc),
        .m_stb      (rd_stb),
        .m_we       (rd_we),
        .m_adr      (rd_adr),
        .m_dat_w    (rd_dat_w),
        .m_dat_r    (rd_dat_r),
        .m_ack      (rd_ack),
        .win_valid, .win_ready, .win_pixels, .win_tap, .win_last
    );

    result_writer u_result_writer (
        .clk, .reset, .start,
        .active     (wr_active),
        .res_valid, .res_data, .res_ready,
        .m_cyc      (wr_cyc),
        .m_stb      (wr_stb),
        .m_we       (wr_we),
        .m_adr      (wr_adr),
        .m_dat_w    (wr_dat_w),
        .m_ack      (wr_ack)
    );

    wb_arbiter u_wb_arbiter (
        .clk, .reset,
        .h_cyc (host_cyc), .h_stb (host_stb), .h_we (host_we),
        .h_adr (host_adr), .h_dat_w (host_dat_w),
        .h_dat_r (host_dat_r), .h_ack (host_ack),
        .w_cyc (wr_cyc), .w_stb (wr_stb), .w_we (wr_we),
        .w_adr (wr_adr), .w_dat_w (wr_dat_w), .w_ack (wr_ack),
        .r_cyc (rd_cyc), .r_stb (rd_stb), .r_we (rd_we),
        .r_adr (rd_adr), .r_dat_w (rd_dat_w),
        .r_dat_r (rd_dat_r), .r_ack (rd_ack),
        .s_cyc (mem_cyc), .s_stb (mem_stb), .s_we (mem_we),
        .s_adr (mem_adr), .s_dat_w (mem_dat_w),
        .s_dat_r (mem_dat_r), .s_ack (mem_ack)
    );

    feature_mem u_feature_mem (
        .clk, .reset,
        .cyc   (mem_cyc),
        .stb   (mem_stb),
        .we    (mem_we),
        .adr   (mem_adr),
        .dat_w (mem_dat_w),
        .dat_r (mem_dat_r),
        .ack   (mem_ack)
    );

endmodule

`default_nettype wire

// File: hw/mem_bus/feature_mem.sv
//////////////////////////////////////////////////////////////////////
// Feature memory: 64 words behind a Wishbone classic slave port
//////////////////////////////////////////////////////////////////////
`default_nettype none

module feature_mem (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [cnn_pkg::MEM_ADDR_W-1:0] adr,
    input  logic [cnn_pkg::WORD_W-1:0]     dat_w,
    output logic [cnn_pkg::WORD_W-1:0]     dat_r,
    output logic                           ack
);

    logic [cnn_pkg::WORD_W-1:0] mem [2**cnn_pkg::MEM_ADDR_W];
    logic                       access;

    // First cycle of a request only
    assign access = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (reset)
            ack <= 1'b0;
        else
            ack <= access;  // Single pulse, dropped after each access
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (we)
                mem[adr] <= dat_w;
            dat_r <= mem[adr];   // Lines up with ack
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_bus/wb_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Wishbone arbiter: fixed priority host, then writer, then reader
//////////////////////////////////////////////////////////////////////
`default_nettype none

module wb_arbiter (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           h_cyc,
    input  logic                           h_stb,
    input  logic                           h_we,
    input  logic [cnn_pkg::MEM_ADDR_W-1:0] h_adr,
    input  logic [cnn_pkg::WORD_W-1:0]     h_dat_w,
    output logic [cnn_pkg::WORD_W-1:0]     h_dat_r,
    output logic                           h_ack,
    input  logic                           w_cyc,   // Write-only master
    input  logic                           w_stb,
    input  logic                           w_we,
    input  logic [cnn_pkg::MEM_ADDR_W-1:0] w_adr,
    input  logic [cnn_pkg::WORD_W-1:0]     w_dat_w,
    output logic                           w_ack,
    input  logic                           r_cyc,
    input  logic                           r_stb,
    input  logic                           r_we,
    input  logic [cnn_pkg::MEM_ADDR_W-1:0] r_adr,
    input  logic [cnn_pkg::WORD_W-1:0]     r_dat_w,
    output logic [cnn_pkg::WORD_W-1:0]     r_dat_r,
    output logic                           r_ack,
    output logic                           s_cyc,
    output logic                           s_stb,
    output logic                           s_we,
    output logic [cnn_pkg::MEM_ADDR_W-1:0] s_adr,
    output logic [cnn_pkg::WORD_W-1:0]     s_dat_w,
    input  logic [cnn_pkg::WORD_W-1:0]     s_dat_r,
    input  logic                           s_ack
);

    logic [2:0] grant;      // {reader, writer, host}
    logic       owner_cyc;

    assign owner_cyc = |(grant & {r_cyc, w_cyc, h_cyc});

    // New grant only from idle, held until owner drops cyc
    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= 3'b000;
        end else if (grant == 3'b000) begin
            if (h_cyc)
                grant <= 3'b001;
            else if (w_cyc)
                grant <= 3'b010;
            else if (r_cyc)
                grant <= 3'b100;
        end else if (!owner_cyc) begin
            grant <= 3'b000;
        end
    end

    always_comb begin
        s_cyc   = 1'b0;
        s_stb   = 1'b0;
        s_we    = 1'b0;
        s_adr   = '0;
        s_dat_w = '0;
        case (grant)
            3'b001: begin
                s_cyc   = h_cyc;
                s_stb   = h_stb;
                s_we    = h_we;
                s_adr   = h_adr;
                s_dat_w = h_dat_w;
            end
            3'b010: begin
                s_cyc   = w_cyc;
                s_stb   = w_stb;
                s_we    = w_we;
                s_adr   = w_adr;
                s_dat_w = w_dat_w;
            end
            3'b100: begin
                s_cyc   = r_cyc;
                s_stb   = r_stb;
                s_we    = r_we;
                s_adr   = r_adr;
                s_dat_w = r_dat_w;
            end
            default: ;
        endcase
    end

    assign h_ack   = s_ack && grant[0];
    assign w_ack   = s_ack && grant[1];
    assign r_ack   = s_ack && grant[2];
    assign h_dat_r = s_dat_r;   // Qualified by ack at each master
    assign r_dat_r = s_dat_r;

    grant_onehot_a: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the conv sequencer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module conv_seq_tb -o conv_seq_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/conv_seq_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: verilog.f
common/cnn_pkg.sv
hw/mem_bus/wb_arbiter.sv
hw/mem_bus/feature_mem.sv
hw/conv_seq/tile_reader.sv
hw/conv_seq/result_writer.sv
hw/conv_seq_top.sv
dv/conv_seq_tb.sv
